/* source/midi_pkg.sv */
package midi_pkg;

    // upper nibble of a channel status byte, channel bits are ignored
    localparam logic [3:0] STATUS_NOTE_OFF = 4'h8;
    localparam logic [3:0] STATUS_NOTE_ON  = 4'h9;
    localparam logic [3:0] STATUS_CTRL     = 4'hB;

    // control change number for all notes off
    localparam logic [6:0] CTRL_ALL_NOTES_OFF = 7'd123;

    // kind of a decoded channel message
    typedef enum logic [1:0] {
        OP_NONE     = 2'd0,
        OP_NOTE_OFF = 2'd1,
        OP_NOTE_ON  = 2'd2,
        OP_CTRL     = 2'd3
    } midi_op_t;

    // one complete two-byte message
    // value is velocity for notes, controller value for control change
    typedef struct packed {
        midi_op_t   op;
        logic [6:0] key;
        logic [6:0] value;
    } midi_msg_t;

endpackage

/* source/voice_pkg.sv */
package voice_pkg;

    // voice array size
    localparam int VOICES  = 8;
    localparam int VOICE_W = 3;

    // envelope level and mixed sum, sum holds VOICES * 127
    localparam int LEVEL_W = 7;
    localparam int MIX_W   = 10;

    // command from the note stack to one voice gate
    // start = 1 starts the voice, start = 0 releases it
    typedef struct packed {
        logic               start;
        logic [VOICE_W-1:0] voice;
        logic [6:0]         key;
        logic [6:0]         velocity;
    } voice_cmd_t;

endpackage

/* source/midi_decoder.sv */
`timescale 1ns/1ps

module midi_decoder
    import midi_pkg::*;
(
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic [7:0] midi_byte,
    input  logic       midi_valid,
    output midi_msg_t  msg,
    output logic       msg_valid
);

    typedef enum logic {
        SLOT_KEY,
        SLOT_VALUE
    } slot_t;

    midi_op_t   run_op;
    midi_op_t   status_op;
    slot_t      slot;
    logic [6:0] held_key;
    logic       data_byte;

    // only note off, note on and control change keep a running status
    always_comb begin
        case (midi_byte[7:4])
            STATUS_NOTE_OFF: status_op = OP_NOTE_OFF;
            STATUS_NOTE_ON:  status_op = OP_NOTE_ON;
            STATUS_CTRL:     status_op = OP_CTRL;
            default:         status_op = OP_NONE;
        endcase
    end

    // data bytes count only while a status is held
    assign data_byte = midi_valid && !midi_byte[7] && (run_op != OP_NONE);

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            run_op    <= OP_NONE;
            slot      <= SLOT_KEY;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (midi_valid && midi_byte[7]) begin
                run_op <= status_op;
                slot   <= SLOT_KEY;
            end else if (data_byte) begin
                if (slot == SLOT_KEY) begin
                    slot <= SLOT_VALUE;
                end else begin
                    // message complete, status stays for the next pair
                    msg_valid <= 1'b1;
                    slot      <= SLOT_KEY;
                end
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (data_byte) begin
            if (slot == SLOT_KEY) begin
                held_key <= midi_byte[6:0];
            end else begin
                msg <= '{op: run_op, key: held_key, value: midi_byte[6:0]};
            end
        end
    end

endmodule

/* source/note_stack.sv */
`timescale 1ns/1ps

module note_stack
    import midi_pkg::*;
    import voice_pkg::*;
(
    input  logic              reg_clk,
    input  logic              reset_reg_N,
    input  midi_msg_t         msg,
    input  logic              msg_valid,
    input  logic [VOICES-1:0] voice_idle,
    output logic [VOICES-1:0] key_on,
    output voice_cmd_t        cmd,
    output logic              cmd_valid,
    output logic              all_off
);

    // key held by each voice, valid where key_on is set
    logic [6:0]         key_tab [VOICES];
    // on-voices, oldest at index 0
    logic [VOICE_W-1:0] age_q [VOICES];
    logic [VOICE_W:0]   age_cnt;

    logic [VOICES-1:0]  key_hit;
    logic               hit_found;
    logic [VOICE_W-1:0] hit_voice;
    logic [VOICES-1:0]  free_mask;
    logic [VOICES-1:0]  open_mask;
    logic [VOICE_W-1:0] sel_voice;
    logic               is_start;
    logic               is_release;
    logic               is_clear;
    logic [VOICE_W-1:0] q_next [VOICES];
    logic [VOICE_W:0]   cnt_next;

    function automatic logic [VOICE_W-1:0] lowest(input logic [VOICES-1:0] mask);
        logic [VOICE_W-1:0] idx;
        idx = '0;
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = VOICE_W'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int v = 0; v < VOICES; v++) begin
            key_hit[v] = key_on[v] && (key_tab[v] == msg.key);
        end
    end

    assign hit_found = |key_hit;
    assign hit_voice = lowest(key_hit);
    assign free_mask = voice_idle & ~key_on;
    assign open_mask = ~key_on;

    // note on with velocity 0 is a note off
    assign is_clear   = msg_valid && (msg.op == OP_CTRL) && (msg.key == CTRL_ALL_NOTES_OFF);
    assign is_start   = msg_valid && (msg.op == OP_NOTE_ON) && (msg.value != '0);
    assign is_release = msg_valid && hit_found &&
                        ((msg.op == OP_NOTE_OFF) || ((msg.op == OP_NOTE_ON) && (msg.value == '0)));

    // a held key is retriggered on its own voice, so a key sits on one voice at most
    always_comb begin
        if (hit_found) begin
            sel_voice = hit_voice;
        end else if (|free_mask) begin
            sel_voice = lowest(free_mask);
        end else if (|open_mask) begin
            // still releasing, cut short
            sel_voice = lowest(open_mask);
        end else begin
            // all held, steal the oldest
            sel_voice = age_q[0];
        end
    end

    // drop the selected voice from the queue, then append it again on a start
    always_comb begin
        int n;
        n = 0;
        for (int i = 0; i < VOICES; i++) begin
            q_next[i] = age_q[i];
        end
        for (int i = 0; i < VOICES; i++) begin
            if ((i < int'(age_cnt)) && (age_q[i] != sel_voice)) begin
                q_next[n] = age_q[i];
                n++;
            end
        end
        if (is_start && (n < VOICES)) begin
            q_next[n] = sel_voice;
            n++;
        end
        cnt_next = n[VOICE_W:0];
    end

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            key_on    <= '0;
            age_cnt   <= '0;
            cmd_valid <= 1'b0;
            all_off   <= 1'b0;
        end else begin
            cmd_valid <= is_start || is_release;
            all_off   <= is_clear;
            if (is_clear) begin
                key_on  <= '0;
                age_cnt <= '0;
            end else if (is_start || is_release) begin
                key_on[sel_voice] <= is_start;
                age_cnt           <= cnt_next;
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (is_start || is_release) begin
            age_q <= q_next;
            cmd   <= '{start: is_start, voice: sel_voice, key: msg.key, velocity: msg.value};
        end
        if (is_start) begin
            key_tab[sel_voice] <= msg.key;
        end
    end

endmodule

/* source/voice_gate.sv */
`timescale 1ns/1ps

module voice_gate
    import voice_pkg::*;
#(
    parameter int VOICE_ID = 0
) (
    input  logic               reg_clk,
    input  logic               reset_reg_N,
    input  voice_cmd_t         cmd,
    input  logic               cmd_valid,
    input  logic               all_off,
    output logic [LEVEL_W-1:0] level,
    output logic               voice_idle
);

    logic               gate;
    logic [6:0]         key;
    logic [LEVEL_W-1:0] target;
    logic               hit;

    assign hit = cmd_valid && (cmd.voice == VOICE_W'(VOICE_ID));

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            gate  <= 1'b0;
            level <= '0;
        end else begin
            if (all_off) begin
                gate <= 1'b0;
            end else if (hit && cmd.start) begin
                gate <= 1'b1;
            end else if (hit && (cmd.key == key)) begin
                // release only for the key this voice is playing
                gate <= 1'b0;
            end

            // linear attack toward target, release toward zero
            if (gate) begin
                if (level < target) begin
                    level <= level + 1'b1;
                end else if (level > target) begin
                    level <= level - 1'b1;
                end
            end else if (level != '0) begin
                level <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (hit && cmd.start) begin
            key    <= cmd.key;
            target <= cmd.velocity;
        end
    end

    assign voice_idle = !gate && (level == '0);

endmodule

/* source/voice_mixer.sv */
`timescale 1ns/1ps

module voice_mixer
    import voice_pkg::*;
(
    input  logic                             reg_clk,
    input  logic                             reset_reg_N,
    input  logic [VOICES-1:0][LEVEL_W-1:0]   levels,
    output logic [MIX_W-1:0]                 mix_out,
    output logic [3:0]                       active_voices
);

    logic [MIX_W-1:0] sum;
    logic [3:0]       count;

    // adder chain over all voices
    always_comb begin
        sum   = '0;
        count = '0;
        for (int v = 0; v < VOICES; v++) begin
            sum = sum + MIX_W'(levels[v]);
            if (levels[v] != '0) begin
                count = count + 4'd1;
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            mix_out       <= '0;
            active_voices <= '0;
        end else begin
            mix_out       <= sum;
            active_voices <= count;
        end
    end

endmodule

/* source/synth_voice_top.sv */
`timescale 1ns/1ps

module synth_voice_top
    import midi_pkg::*;
    import voice_pkg::*;
(
    input  logic              reg_clk,
    input  logic              reset_reg_N,
    input  logic [7:0]        midi_byte,
    input  logic              midi_valid,
    output logic [VOICES-1:0] key_on,
    output logic [MIX_W-1:0]  mix_out,
    output logic [3:0]        active_voices
);

    midi_msg_t                      msg;
    logic                           msg_valid;
    voice_cmd_t                     cmd;
    logic                           cmd_valid;
    logic                           all_off;
    logic [VOICES-1:0]              voice_idle;
    logic [VOICES-1:0][LEVEL_W-1:0] levels;

    midi_decoder u_decoder (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .midi_byte   (midi_byte),
        .midi_valid  (midi_valid),
        .msg         (msg),
        .msg_valid   (msg_valid)
    );

    note_stack u_note_stack (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .msg         (msg),
        .msg_valid   (msg_valid),
        .voice_idle  (voice_idle),
        .key_on      (key_on),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .all_off     (all_off)
    );

    // one gate and envelope per voice
    for (genvar g = 0; g < VOICES; g++) begin : g_voice
        voice_gate #(
            .VOICE_ID (g)
        ) u_voice (
            .reg_clk     (reg_clk),
            .reset_reg_N (reset_reg_N),
            .cmd         (cmd),
            .cmd_valid   (cmd_valid),
            .all_off     (all_off),
            .level       (levels[g]),
            .voice_idle  (voice_idle[g])
        );
    end

    voice_mixer u_mixer (
        .reg_clk       (reg_clk),
        .reset_reg_N   (reset_reg_N),
        .levels        (levels),
        .mix_out       (mix_out),
        .active_voices (active_voices)
    );

endmodule

/* testbench/tb_synth_voice.sv */
`timescale 1ns/1ps

module tb_synth_voice
    import midi_pkg::*;
    import voice_pkg::*;
();

    logic               reg_clk;
    logic               reset_reg_N;
    logic [7:0]         midi_byte;
    logic               midi_valid;
    logic [VOICES-1:0]  key_on;
    logic [MIX_W-1:0]   mix_out;
    logic [3:0]         active_voices;

    int          value_errors;
    int          timeout_errors;
    logic [31:0] lfsr_state;

    synth_voice_top dut_i (
        .reg_clk       (reg_clk),
        .reset_reg_N   (reset_reg_N),
        .midi_byte     (midi_byte),
        .midi_valid    (midi_valid),
        .key_on        (key_on),
        .mix_out       (mix_out),
        .active_voices (active_voices)
    );

    always #2 reg_clk = ~reg_clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // seven bits, one step each, zero bumped to 1
    function automatic logic [6:0] rand_velocity();
        logic [6:0] v;
        v = '0;
        for (int b = 0; b < 7; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[5:0], lfsr_state[0]};
        end
        if (v == '0) begin
            v = 7'd1;
        end
        return v;
    endfunction

    task automatic check_keys(input logic [VOICES-1:0] exp, input string what);
        if (key_on !== exp) begin
            $display("Error key_on: expected 0x%h, got 0x%h (%s)", exp, key_on, what);
            value_errors++;
        end
    endtask

    task automatic check_mix(input logic [MIX_W-1:0] exp, input string what);
        if (mix_out !== exp) begin
            $display("Error mix_out: expected 0x%h, got 0x%h (%s)", exp, mix_out, what);
            value_errors++;
        end
    endtask

    task automatic check_count(input logic [3:0] exp, input string what);
        if (active_voices !== exp) begin
            $display("Error active_voices: expected 0x%h, got 0x%h (%s)",
                     exp, active_voices, what);
            value_errors++;
        end
    endtask

    task automatic apply_reset();
        reset_reg_N = 1'b0;
        midi_valid  = 1'b0;
        repeat (8) @(negedge reg_clk);
        reset_reg_N = 1'b1;
        check_keys('0, "after reset");
        check_mix('0, "after reset");
        check_count('0, "after reset");
    endtask

    // one strobed byte, valid dropped on the next falling edge
    task automatic send_byte(input logic [7:0] b);
        @(negedge reg_clk);
        midi_byte  = b;
        midi_valid = 1'b1;
        @(negedge reg_clk);
        midi_valid = 1'b0;
    endtask

    task automatic send_pair(input logic [6:0] key, input logic [6:0] value);
        send_byte({1'b0, key});
        send_byte({1'b0, value});
    endtask

    task automatic send_note_on(input logic [6:0] key, input logic [6:0] vel);
        send_byte({STATUS_NOTE_ON, 4'h0});
        send_pair(key, vel);
    endtask

    task automatic send_note_off(input logic [6:0] key);
        send_byte({STATUS_NOTE_OFF, 4'h0});
        send_pair(key, 7'd64);
    endtask

    task automatic send_ctrl(input logic [6:0] num, input logic [6:0] value);
        send_byte({STATUS_CTRL, 4'h3});
        send_pair(num, value);
    endtask

    // key_on moves two cycles after the last strobe
    task automatic expect_keys(input logic [VOICES-1:0] exp, input string what);
        @(negedge reg_clk);
        check_keys(exp, what);
    endtask

    task automatic wait_settle();
        logic [MIX_W-1:0] last_mix;
        logic [3:0]       last_count;
        int               stable;
        int               cycles;
        stable     = 0;
        cycles     = 0;
        last_mix   = mix_out;
        last_count = active_voices;
        while ((stable < 130) && (cycles < 2000)) begin
            @(negedge reg_clk);
            cycles++;
            if ((mix_out == last_mix) && (active_voices == last_count)) begin
                stable++;
            end else begin
                stable     = 0;
                last_mix   = mix_out;
                last_count = active_voices;
            end
        end
        if (stable < 130) begin
            $display("mix_out and active_voices did not settle within 2000 cycles");
            timeout_errors++;
        end
    endtask

    task automatic alloc_three();
        logic [6:0] vel [3];
        apply_reset();
        vel[0] = rand_velocity();
        vel[1] = rand_velocity();
        vel[2] = rand_velocity();
        send_note_on(7'd60, vel[0]);
        expect_keys(8'h01, "alloc first");
        send_note_on(7'd64, vel[1]);
        expect_keys(8'h03, "alloc second");
        send_note_on(7'd67, vel[2]);
        expect_keys(8'h07, "alloc third");
        wait_settle();
        check_keys(8'h07, "alloc settled");
        check_count(4'd3, "alloc settled");
        check_mix(MIX_W'(int'(vel[0]) + vel[1] + vel[2]), "alloc settled");
    endtask

    task automatic release_keys();
        logic [6:0] vel [4];
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            vel[i] = rand_velocity();
        end
        send_note_on(7'd60, vel[0]);
        send_note_on(7'd64, vel[1]);
        send_note_on(7'd67, vel[2]);
        send_note_on(7'd72, vel[3]);
        expect_keys(8'h0F, "release setup");
        wait_settle();
        check_mix(MIX_W'(int'(vel[0]) + vel[1] + vel[2] + vel[3]), "release setup");
        send_note_off(7'd64);
        expect_keys(8'h0D, "note off middle key");
        send_note_on(7'd67, 7'd0);
        expect_keys(8'h09, "note on velocity zero");
        wait_settle();
        check_count(4'd2, "after releases");
        check_mix(MIX_W'(int'(vel[0]) + vel[3]), "after releases");
        // key 50 is not held
        send_note_off(7'd50);
        expect_keys(8'h09, "note off unheld key");
        wait_settle();
        check_count(4'd2, "unheld key ignored");
        check_mix(MIX_W'(int'(vel[0]) + vel[3]), "unheld key ignored");
    endtask

    task automatic running_status();
        logic [6:0]        vel [4];
        logic [VOICES-1:0] exp;
        int                sum;
        apply_reset();
        sum = 0;
        exp = '0;
        send_byte({STATUS_NOTE_ON, 4'h5});
        for (int i = 0; i < 4; i++) begin
            vel[i] = rand_velocity();
            sum += vel[i];
            exp[i] = 1'b1;
            send_pair(7'(48 + 4 * i), vel[i]);
            expect_keys(exp, "running status pair");
        end
        wait_settle();
        check_count(4'd4, "running status settled");
        check_mix(MIX_W'(sum), "running status settled");
    endtask

    task automatic steal_oldest();
        logic [6:0]        vel [9];
        logic [VOICES-1:0] exp;
        int                sum;
        apply_reset();
        sum = 0;
        exp = '0;
        for (int i = 0; i < 9; i++) begin
            vel[i] = rand_velocity();
            if (i < VOICES) begin
                exp[i] = 1'b1;
            end
            if (i > 0) begin
                sum += vel[i];
            end
            send_note_on(7'(40 + i), vel[i]);
            expect_keys(exp, "steal sequence");
        end
        wait_settle();
        check_keys(8'hFF, "steal settled");
        check_count(4'd8, "steal settled");
        // voice 0 now plays the ninth note
        check_mix(MIX_W'(sum), "steal settled");
    endtask

    task automatic all_notes_off();
        logic [6:0] vel [3];
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            vel[i] = rand_velocity();
            send_note_on(7'(70 + i), vel[i]);
        end
        wait_settle();
        // volume controller, not all notes off
        send_ctrl(7'd7, 7'd100);
        expect_keys(8'h07, "other controller");
        wait_settle();
        check_count(4'd3, "other controller");
        check_mix(MIX_W'(int'(vel[0]) + vel[1] + vel[2]), "other controller");
        send_ctrl(CTRL_ALL_NOTES_OFF, 7'd0);
        expect_keys(8'h00, "all notes off");
        wait_settle();
        check_count(4'd0, "all notes off settled");
        check_mix('0, "all notes off settled");
    endtask

    task automatic reuse_voice();
        logic [6:0] vel [4];
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            vel[i] = rand_velocity();
        end
        send_note_on(7'd60, vel[0]);
        send_note_on(7'd62, vel[1]);
        send_note_on(7'd64, vel[2]);
        send_note_off(7'd62);
        expect_keys(8'h05, "reuse release");
        wait_settle();
        send_note_on(7'd65, vel[3]);
        expect_keys(8'h07, "reuse lowest free");
        wait_settle();
        check_count(4'd3, "reuse settled");
        check_mix(MIX_W'(int'(vel[0]) + vel[2] + vel[3]), "reuse settled");
    endtask

    initial begin
        reg_clk        = 1'b0;
        reset_reg_N    = 1'b0;
        midi_byte      = 8'h00;
        midi_valid     = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        lfsr_state     = 32'h3447;

        alloc_three();
        release_keys();
        running_status();
        steal_oldest();
        all_notes_off();
        reuse_voice();

        $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if ((value_errors == 0) && (timeout_errors == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* project.f */
source/midi_pkg.sv
source/voice_pkg.sv
source/midi_decoder.sv
source/note_stack.sv
source/voice_gate.sv
source/voice_mixer.sv
source/synth_voice_top.sv
testbench/tb_synth_voice.sv

/* Bender.yml */
package:
  name: synth_voice

sources:
  - source/midi_pkg.sv
  - source/voice_pkg.sv
  - source/midi_decoder.sv
  - source/note_stack.sv
  - source/voice_gate.sv
  - source/voice_mixer.sv
  - source/synth_voice_top.sv
  - target: test
    files:
      - testbench/tb_synth_voice.sv
